/* gen3_rx_lane.f */
+incdir+logic
+incdir+test
logic/gen3_rx_pkg.sv
logic/gen3_lfsr_step.sv
logic/gen3_block_aligner.sv
logic/gen3_rx_fifo.sv
logic/gen3_descramble.sv
logic/gen3_rx_lane.sv
test/tb_gen3_rx_lane.sv

/* Bender.yml */
package:
  name: gen3_rx_lane

sources:
  - include_dirs:
      - logic
    files:
      - logic/gen3_rx_pkg.sv
      - logic/gen3_lfsr_step.sv
      - logic/gen3_block_aligner.sv
      - logic/gen3_rx_fifo.sv
      - logic/gen3_descramble.sv
      - logic/gen3_rx_lane.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/tb_gen3_rx_lane.sv

/* test/tb_gen3_rx_model.svh */
`ifndef TB_GEN3_RX_MODEL_SVH
`define TB_GEN3_RX_MODEL_SVH

// Terms x^21, x^16, x^8, x^5, x^2 and 1 of the Gen3 scrambler polynomial
// The x^23 term is the bit that leaves stage 22 on each shift
localparam gen3_rx_pkg::lfsr_t POLY_TERMS = (24'd1 << 21) | (24'd1 << 16) | (24'd1 << 8) |
                                            (24'd1 << 5) | (24'd1 << 2) | 24'd1;

// Transmitter side scrambler state and the block being built
gen3_rx_pkg::lfsr_t  model_lfsr;
gen3_rx_pkg::dword_t plain_blk [`GEN3_DW_PER_BLOCK];
gen3_rx_pkg::dword_t tx_blk    [`GEN3_DW_PER_BLOCK];

task automatic model_reseed(input gen3_rx_pkg::lane_num_t lane);
  model_lfsr = gen3_rx_pkg::gen3_seed(lane);
endtask

// Eight bit times, the first bit out scrambles bit 0 of the symbol
task automatic model_next_key(output gen3_rx_pkg::symbol_t key);
  logic fb;
  key = '0;
  for (int b = 0; b < 8; b++) begin
    fb         = model_lfsr[22];
    key[b]     = fb;
    model_lfsr = {1'b0, model_lfsr[21:0], 1'b0};
    if (fb) model_lfsr = model_lfsr ^ POLY_TERMS;
  end
endtask

// Turns plain_blk into tx_blk the way the far end transmitter does
// SKP holds the scrambler, EIEOS and TS symbol 0 go out in the clear
task automatic model_scramble_block(input logic os);
  gen3_rx_pkg::symbol_t sym0;
  gen3_rx_pkg::symbol_t key;
  logic                 skp;
  logic                 eieos;
  logic                 ts;
  sym0  = plain_blk[0][7:0];
  skp   = os && (sym0 == gen3_rx_pkg::GEN3_SKP);
  eieos = os && (sym0 == gen3_rx_pkg::EIEOS);
  ts    = os && ((sym0 == gen3_rx_pkg::TS1OS) || (sym0 == gen3_rx_pkg::TS2OS));
  for (int d = 0; d < `GEN3_DW_PER_BLOCK; d++) begin
    for (int i = 0; i < 4; i++) begin
      if (skp) begin
        tx_blk[d][8*i +: 8] = plain_blk[d][8*i +: 8];
      end else begin
        model_next_key(key);
        if (eieos || (ts && (d == 0) && (i == 0))) tx_blk[d][8*i +: 8] = plain_blk[d][8*i +: 8];
        else tx_blk[d][8*i +: 8] = plain_blk[d][8*i +: 8] ^ key;
      end
    end
  end
endtask

`endif

/* test/tb_gen3_rx_lane.sv */
`timescale 1ns/100ps
`include "gen3_rx_cfg.svh"

module tb_gen3_rx_lane;

  // Each test needs about 50 cycles including reset and the quiet check
  // Seven tests stay far below this bound
  localparam int CYCLE_LIMIT = 2000;

  logic                   clk_i;
  logic                   rst_i;
  gen3_rx_pkg::lane_num_t lane_i;
  logic                   in_valid_i;
  gen3_rx_pkg::dword_t    in_data_i;
  gen3_rx_pkg::sync_hdr_t in_sync_i;
  logic                   in_ready_o;
  logic                   out_ready_i;
  logic                   out_valid_o;
  gen3_rx_pkg::dword_t    out_data_o;
  logic                   out_is_os_o;
  logic                   overflow_o;
  logic                   sync_err_o;

  integer              seed   = 26007;
  int                  cycles = 0;
  gen3_rx_pkg::dword_t got_data_q [$];
  logic                got_os_q   [$];
  gen3_rx_pkg::dword_t exp_data_q [$];
  logic                exp_os_q   [$];

  `include "tb_gen3_rx_model.svh"

  gen3_rx_lane dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .lane_i      (lane_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_sync_i   (in_sync_i),
    .in_ready_o  (in_ready_o),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_is_os_o (out_is_os_o),
    .overflow_o  (overflow_o),
    .sync_err_o  (sync_err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Outputs are collected mid-cycle, well away from the driving edge
  always @(negedge clk_i) begin
    if (!rst_i && out_valid_o) begin
      got_data_q.push_back(out_data_o);
      got_os_q.push_back(out_is_os_o);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  task automatic compare_dword(input string what, input gen3_rx_pkg::dword_t got,
                               input gen3_rx_pkg::dword_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic compare_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  function automatic gen3_rx_pkg::dword_t random_dword();
    return $random(seed);
  endfunction

  // The lane is changed under reset so the descrambler loads its seed
  task automatic apply_reset(input gen3_rx_pkg::lane_num_t lane, input logic ready);
    @(posedge clk_i);
    rst_i       <= 1'b1;
    lane_i      <= lane;
    in_valid_i  <= 1'b0;
    out_ready_i <= ready;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    got_data_q.delete();
    got_os_q.delete();
    exp_data_q.delete();
    exp_os_q.delete();
    model_reseed(lane);
  endtask

  task automatic drive_dword(input gen3_rx_pkg::dword_t data, input gen3_rx_pkg::sync_hdr_t sync);
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    in_data_i  <= data;
    in_sync_i  <= sync;
  endtask

  task automatic idle_input();
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  // Random plaintext, optionally with a fixed symbol 0 that names an ordered set
  task automatic fill_block(input logic set_sym0, input gen3_rx_pkg::symbol_t sym0);
    for (int d = 0; d < `GEN3_DW_PER_BLOCK; d++) plain_blk[d] = random_dword();
    if (set_sym0) plain_blk[0][7:0] = sym0;
  endtask

  // Sends tx_blk with the given header on its first dword only
  task automatic drive_raw_block(input gen3_rx_pkg::sync_hdr_t sync);
    for (int d = 0; d < `GEN3_DW_PER_BLOCK; d++) drive_dword(tx_blk[d], (d == 0) ? sync : 2'b00);
  endtask

  task automatic send_block(input logic os);
    model_scramble_block(os);
    drive_raw_block(os ? gen3_rx_pkg::SYNC_OS : gen3_rx_pkg::SYNC_DATA);
    for (int d = 0; d < `GEN3_DW_PER_BLOCK; d++) begin
      exp_data_q.push_back(plain_blk[d]);
      exp_os_q.push_back(os);
    end
  endtask

  // Waits for every expected word, compares in order, then checks for strays
  task automatic check_outputs();
    int n;
    n = exp_data_q.size();
    while (got_data_q.size() < n) @(posedge clk_i);
    for (int k = 0; k < n; k++) begin
      compare_dword($sformatf("output word %0d", k), got_data_q.pop_front(), exp_data_q.pop_front());
      compare_flag($sformatf("out_is_os_o of word %0d", k), got_os_q.pop_front(), exp_os_q.pop_front());
    end
    repeat (8) @(posedge clk_i);
    compare_flag("no extra output word", got_data_q.size() == 0, 1'b1);
  endtask

  task automatic test_data_blocks(input gen3_rx_pkg::lane_num_t lane);
    apply_reset(lane, 1'b1);
    for (int b = 0; b < 3; b++) begin
      fill_block(1'b0, 8'h00);
      send_block(1'b0);
    end
    idle_input();
    check_outputs();
  endtask

  // A data block follows every ordered set to show where the LFSR ended up
  task automatic test_ordered_set(input gen3_rx_pkg::symbol_t sym0);
    apply_reset(3'd3, 1'b1);
    fill_block(1'b0, 8'h00);
    send_block(1'b0);
    fill_block(1'b1, sym0);
    send_block(1'b1);
    // The transmitter restarts its scrambler from the seed after an EIEOS
    if (sym0 == gen3_rx_pkg::EIEOS) model_reseed(3'd3);
    fill_block(1'b0, 8'h00);
    send_block(1'b0);
    idle_input();
    check_outputs();
  endtask

  task automatic test_overflow();
    apply_reset(3'd6, 1'b0);
    for (int b = 0; b < 2; b++) begin
      fill_block(1'b0, 8'h00);
      send_block(1'b0);
    end
    idle_input();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    compare_flag("in_ready_o with a full FIFO", in_ready_o, 1'b0);
    compare_flag("overflow_o before the extra words", overflow_o, 1'b0);
    // This block is lost, so the receiver LFSR never sees it
    fill_block(1'b0, 8'h00);
    for (int d = 0; d < `GEN3_DW_PER_BLOCK; d++) tx_blk[d] = plain_blk[d];
    drive_raw_block(gen3_rx_pkg::SYNC_DATA);
    idle_input();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    compare_flag("overflow_o after the extra words", overflow_o, 1'b1);
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    check_outputs();
  endtask

  task automatic test_bad_sync();
    apply_reset(3'd1, 1'b1);
    fill_block(1'b0, 8'h00);
    for (int d = 0; d < `GEN3_DW_PER_BLOCK; d++) tx_blk[d] = plain_blk[d];
    drive_raw_block(2'b11);
    fill_block(1'b0, 8'h00);
    send_block(1'b0);
    idle_input();
    @(negedge clk_i);
    compare_flag("sync_err_o after header 11", sync_err_o, 1'b1);
    check_outputs();
  endtask

  initial begin
    rst_i       = 1'b1;
    lane_i      = '0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    in_sync_i   = '0;
    out_ready_i = 1'b1;
    test_data_blocks(3'd0);
    test_data_blocks(3'd5);
    test_ordered_set(gen3_rx_pkg::GEN3_SKP);
    test_ordered_set(gen3_rx_pkg::EIEOS);
    test_ordered_set(gen3_rx_pkg::TS1OS);
    test_overflow();
    test_bad_sync();
    $display("TEST PASS");
    $finish;
  end

endmodule

/* logic/gen3_rx_lane.sv */
`timescale 1ns/100ps

module gen3_rx_lane (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  gen3_rx_pkg::lane_num_t lane_i,
  input  logic                   in_valid_i,
  input  gen3_rx_pkg::dword_t    in_data_i,
  input  gen3_rx_pkg::sync_hdr_t in_sync_i,
  output logic                   in_ready_o,
  input  logic                   out_ready_i,
  output logic                   out_valid_o,
  output gen3_rx_pkg::dword_t    out_data_o,
  output logic                   out_is_os_o,
  output logic                   overflow_o,
  output logic                   sync_err_o
);

  logic                wr_en;
  gen3_rx_pkg::dword_t wr_data;
  logic                wr_os;
  logic                wr_first;
  logic                rd_en;
  logic                rd_valid;
  gen3_rx_pkg::dword_t rd_data;
  logic                rd_os;
  logic                rd_first;
  logic                fifo_full;
  logic                fifo_empty;

  // Pop whenever a word is buffered and downstream accepts
  // A popped word still takes two cycles to reach the output
  assign rd_en      = !fifo_empty && out_ready_i;
  assign in_ready_o = !fifo_full;

  gen3_block_aligner u_aligner (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (in_valid_i),
    .data_i     (in_data_i),
    .sync_i     (in_sync_i),
    .valid_o    (wr_en),
    .data_o     (wr_data),
    .os_o       (wr_os),
    .first_o    (wr_first),
    .sync_err_o (sync_err_o)
  );

  // Words that arrive with in_ready_o low are dropped here and flag overflow
  gen3_rx_fifo u_fifo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_en_i    (wr_en),
    .wr_data_i  (wr_data),
    .wr_os_i    (wr_os),
    .wr_first_i (wr_first),
    .rd_en_i    (rd_en),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_data),
    .rd_os_o    (rd_os),
    .rd_first_o (rd_first),
    .full_o     (fifo_full),
    .empty_o    (fifo_empty),
    .overflow_o (overflow_o)
  );

  gen3_descramble u_descramble (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .lane_i  (lane_i),
    .valid_i (rd_valid),
    .data_i  (rd_data),
    .os_i    (rd_os),
    .first_i (rd_first),
    .valid_o (out_valid_o),
    .data_o  (out_data_o),
    .is_os_o (out_is_os_o)
  );

endmodule

/* logic/gen3_descramble.sv */
`timescale 1ns/100ps

module gen3_descramble (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  gen3_rx_pkg::lane_num_t lane_i,
  input  logic                   valid_i,
  input  gen3_rx_pkg::dword_t    data_i,
  input  logic                   os_i,
  input  logic                   first_i,
  output logic                   valid_o,
  output gen3_rx_pkg::dword_t    data_o,
  output logic                   is_os_o
);

  gen3_rx_pkg::lfsr_t   lfsr_r;
  gen3_rx_pkg::lfsr_t   lfsr_nxt;
  gen3_rx_pkg::lfsr_t   lfsr_chain [5];
  gen3_rx_pkg::symbol_t key        [4];
  gen3_rx_pkg::symbol_t sym0;
  gen3_rx_pkg::dw_idx_t pos_r;
  gen3_rx_pkg::dw_idx_t pos_c;
  gen3_rx_pkg::dword_t  plain_c;
  logic                 eieos_r;
  logic                 ts_r;
  logic                 skp_r;
  logic                 eieos_c;
  logic                 ts_c;
  logic                 skp_c;
  logic                 last_c;
  logic [3:0]           bypass_c;

  // One LFSR step per byte lane, byte 0 is the earliest symbol of the dword
  assign lfsr_chain[0] = lfsr_r;

  for (genvar i = 0; i < 4; i++) begin : gen_step
    gen3_lfsr_step u_step (
      .lfsr_i (lfsr_chain[i]),
      .hold_i (skp_c),
      .lfsr_o (lfsr_chain[i+1]),
      .key_o  (key[i])
    );
  end

  assign sym0 = data_i[7:0];

  // Classify the block from symbol 0 of its first dword
  // Later dwords of the same block reuse the registered class
  always_comb begin
    eieos_c = eieos_r;
    ts_c    = ts_r;
    skp_c   = skp_r;
    if (valid_i && first_i) begin
      // Data blocks clear all three flags
      eieos_c = os_i && (sym0 == gen3_rx_pkg::EIEOS);
      ts_c    = os_i && ((sym0 == gen3_rx_pkg::TS1OS) || (sym0 == gen3_rx_pkg::TS2OS));
      skp_c   = os_i && (sym0 == gen3_rx_pkg::GEN3_SKP);
    end
  end

  // Dword position inside the block, restarted by every first dword
  assign pos_c  = first_i ? '0 : pos_r;
  assign last_c = valid_i && (pos_c == gen3_rx_pkg::DW_LAST);

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      // Whole EIEOS and SKP blocks pass as received
      // For TS1 and TS2 only symbol 0 is sent in the clear
      bypass_c[i] = skp_c || eieos_c || (ts_c && first_i && (i == 0));
      plain_c[8*i +: 8] = bypass_c[i] ? data_i[8*i +: 8] : data_i[8*i +: 8] ^ key[i];
    end
  end

  // The LFSR restarts from the seed once the last EIEOS dword is in
  // On SKP blocks the steps hold, so the chain end equals the current state
  always_comb begin
    lfsr_nxt = lfsr_r;
    if (valid_i) begin
      if (eieos_c && last_c) begin
        lfsr_nxt = gen3_rx_pkg::gen3_seed(lane_i);
      end else begin
        lfsr_nxt = lfsr_chain[4];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_r  <= gen3_rx_pkg::gen3_seed(lane_i);
      pos_r   <= '0;
      eieos_r <= 1'b0;
      ts_r    <= 1'b0;
      skp_r   <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      lfsr_r  <= lfsr_nxt;
      eieos_r <= eieos_c;
      ts_r    <= ts_c;
      skp_r   <= skp_c;
      valid_o <= valid_i;
      if (valid_i) pos_r <= pos_c + 1'b1;
    end
  end

  // Output word and its block type, qualified by valid_o
  always_ff @(posedge clk_i) begin
    data_o  <= plain_c;
    is_os_o <= os_i;
  end

  // A zero state would lock the scrambler and give a constant keystream
  a_lfsr_nonzero: assert property (@(posedge clk_i) disable iff (rst_i) lfsr_r != '0);

endmodule

/* logic/gen3_rx_fifo.sv */
`timescale 1ns/100ps
`include "gen3_rx_cfg.svh"

module gen3_rx_fifo (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wr_en_i,
  input  gen3_rx_pkg::dword_t wr_data_i,
  input  logic                wr_os_i,
  input  logic                wr_first_i,
  input  logic                rd_en_i,
  output logic                rd_valid_o,
  output gen3_rx_pkg::dword_t rd_data_o,
  output logic                rd_os_o,
  output logic                rd_first_o,
  output logic                full_o,
  output logic                empty_o,
  output logic                overflow_o
);

  localparam int DEPTH = `GEN3_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam gen3_rx_pkg::fifo_cnt_t CNT_MAX = gen3_rx_pkg::fifo_cnt_t'(DEPTH);

  gen3_rx_pkg::dword_t     mem_data  [DEPTH];
  logic                    mem_os    [DEPTH];
  logic                    mem_first [DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  gen3_rx_pkg::fifo_cnt_t  count;
  logic                    do_wr;
  logic                    do_rd;

  assign do_wr   = wr_en_i && (count != CNT_MAX);
  assign do_rd   = rd_en_i && !empty_o;
  assign empty_o = (count == '0);
  // Full is flagged one slot early
  // The aligner stage may still hold a word that was accepted in the same cycle
  assign full_o  = (count >= CNT_MAX - 1'b1);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      rd_valid_o <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      rd_valid_o <= do_rd;
      if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky until reset
      if (wr_en_i && !do_wr) overflow_o <= 1'b1;
    end
  end

  // Storage and the registered read port
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_data[wr_ptr]  <= wr_data_i;
      mem_os[wr_ptr]    <= wr_os_i;
      mem_first[wr_ptr] <= wr_first_i;
    end
    if (do_rd) begin
      rd_data_o  <= mem_data[rd_ptr];
      rd_os_o    <= mem_os[rd_ptr];
      rd_first_o <= mem_first[rd_ptr];
    end
  end

  a_count_range: assert property (@(posedge clk_i) disable iff (rst_i) count <= CNT_MAX);
  // The pop logic outside must never ask for a word that is not there
  a_no_empty_read: assert property (@(posedge clk_i) disable iff (rst_i) rd_en_i |-> !empty_o);

endmodule

/* logic/gen3_block_aligner.sv */
`timescale 1ns/100ps

module gen3_block_aligner (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  gen3_rx_pkg::dword_t    data_i,
  input  gen3_rx_pkg::sync_hdr_t sync_i,
  output logic                   valid_o,
  output gen3_rx_pkg::dword_t    data_o,
  output logic                   os_o,
  output logic                   first_o,
  output logic                   sync_err_o
);

  gen3_rx_pkg::align_state_t state_r;
  gen3_rx_pkg::dw_idx_t      dw_cnt;
  logic                      blk_os;
  logic                      hdr_ok;
  logic                      blk_last;

  // Only 10 and 01 are legal headers
  assign hdr_ok = (sync_i == gen3_rx_pkg::SYNC_OS) || (sync_i == gen3_rx_pkg::SYNC_DATA);
  assign blk_last = (dw_cnt == gen3_rx_pkg::DW_LAST);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r    <= gen3_rx_pkg::IDLE;
      dw_cnt     <= '0;
      blk_os     <= 1'b0;
      valid_o    <= 1'b0;
      sync_err_o <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      if (valid_i) begin
        // The counter runs on every accepted dword, also inside a dropped block
        dw_cnt <= blk_last ? '0 : dw_cnt + 1'b1;
        case (state_r)
          gen3_rx_pkg::IDLE: begin
            if (hdr_ok) begin
              state_r <= gen3_rx_pkg::IN_BLOCK;
              blk_os  <= (sync_i == gen3_rx_pkg::SYNC_OS);
              valid_o <= 1'b1;
            end else begin
              // Bad header, swallow the remaining dwords of this block
              state_r    <= gen3_rx_pkg::BAD_HDR;
              sync_err_o <= 1'b1;
            end
          end
          gen3_rx_pkg::IN_BLOCK: begin
            valid_o <= 1'b1;
            if (blk_last) state_r <= gen3_rx_pkg::IDLE;
          end
          default: begin
            if (blk_last) state_r <= gen3_rx_pkg::IDLE;
          end
        endcase
      end
    end
  end

  // Tags for the dword, the first one takes its type straight from the header
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_o  <= data_i;
      first_o <= (state_r == gen3_rx_pkg::IDLE);
      os_o    <= (state_r == gen3_rx_pkg::IDLE) ? (sync_i == gen3_rx_pkg::SYNC_OS) : blk_os;
    end
  end

  // A tagged first dword must have been taken at block position zero
  a_first_at_zero: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && first_o |-> $past(dw_cnt) == '0);

endmodule

/* logic/gen3_lfsr_step.sv */
`timescale 1ns/100ps

module gen3_lfsr_step (
  input  gen3_rx_pkg::lfsr_t   lfsr_i,
  input  logic                 hold_i,
  output gen3_rx_pkg::lfsr_t   lfsr_o,
  output gen3_rx_pkg::symbol_t key_o
);

  // Galois feedback taps of x^23+x^21+x^16+x^8+x^5+x^2+1
  localparam gen3_rx_pkg::lfsr_t FB_TAPS = 24'h21_0125;

  gen3_rx_pkg::lfsr_t state;
  logic               fb;

  // Eight bit times per symbol
  // The first bit out lands in key bit 0 because symbols are scrambled LSB first
  always_comb begin
    state = lfsr_i;
    fb    = 1'b0;
    key_o = '0;
    for (int b = 0; b < 8; b++) begin
      // Stage 22 leaves the register and feeds the taps back in
      fb       = state[22];
      key_o[b] = fb;
      state    = {1'b0, state[21:0], 1'b0} ^ (fb ? FB_TAPS : '0);
    end
  end

  // SKP symbols do not advance the scrambler
  assign lfsr_o = hold_i ? lfsr_i : state;

endmodule

/* logic/gen3_rx_pkg.sv */
`include "gen3_rx_cfg.svh"

package gen3_rx_pkg;

  // One lane data word, symbol 0 of the dword sits in the low byte
  typedef logic [`GEN3_DATA_W-1:0] dword_t;
  typedef logic [7:0] symbol_t;
  typedef logic [`GEN3_LFSR_W-1:0] lfsr_t;
  typedef logic [1:0] sync_hdr_t;
  typedef logic [2:0] lane_num_t;

  // Occupancy has to reach the full depth, so one bit wider than a pointer
  typedef logic [3:0] fifo_cnt_t;

  // Position of a dword inside its block
  typedef logic [$clog2(`GEN3_DW_PER_BLOCK)-1:0] dw_idx_t;

  // Index of the last dword of a block
  localparam dw_idx_t DW_LAST = dw_idx_t'(`GEN3_DW_PER_BLOCK - 1);

  typedef enum logic [1:0] {
    IDLE,
    IN_BLOCK,
    BAD_HDR
  } align_state_t;

  // Sync header codes, the other two values are illegal
  localparam sync_hdr_t SYNC_OS   = 2'b10;
  localparam sync_hdr_t SYNC_DATA = 2'b01;

  // Symbol 0 codes of the ordered sets that change descrambling
  localparam symbol_t EIEOS    = 8'h00;
  localparam symbol_t TS1OS    = 8'h1E;
  localparam symbol_t TS2OS    = 8'h2D;
  localparam symbol_t GEN3_SKP = 8'hAA;

  // Per-lane LFSR seed from the Gen3 scrambler definition
  function automatic lfsr_t gen3_seed(lane_num_t lane);
    case (lane)
      3'd0:    return 24'h1D_BFBC;
      3'd1:    return 24'h06_07BB;
      3'd2:    return 24'h1E_C760;
      3'd3:    return 24'h18_C0DB;
      3'd4:    return 24'h01_0F12;
      3'd5:    return 24'h19_CFC9;
      3'd6:    return 24'h02_77CE;
      default: return 24'h1B_B807;
    endcase
  endfunction

endpackage

/* logic/gen3_rx_cfg.svh */
`ifndef GEN3_RX_CFG_SVH
`define GEN3_RX_CFG_SVH

// Width of one lane data word on the fixed 32-bit PIPE interface
`define GEN3_DATA_W 32

// Width of the scrambler state register
// The Gen3 polynomial has degree 23, so the top bit stays clear
`define GEN3_LFSR_W 24

// Number of buffered dwords between the aligner and the descrambler
`define GEN3_FIFO_DEPTH 8

// A 128b/130b block carries 16 symbols, which is four dwords at 32 bits
`define GEN3_DW_PER_BLOCK 4

`endif
